// File: logic/msx_media_pkg.sv
`default_nettype none

package msx_media_pkg;

   // ====================
   // External memory port
   // ====================
   localparam int DDR_ADDR_W = 28;
   typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;

   // ====================
   // System RAM port
   // ====================
   localparam int RAM_ADDR_W = 27;
   typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

   typedef logic [7:0]  byte_t;
   typedef logic [15:0] copy_len_t;

   // Tape image region in external memory
   localparam ddr_addr_t TAPE_BASE = 28'h0700000;

   // Clock cycles per serial tape bit
   localparam int BIT_TICKS = 8;
   localparam int TICK_W    = $clog2(BIT_TICKS);

   // Activity light hold time after the last SD line change
   localparam int ACT_HOLD_CYCLES = 64;
   localparam int ACT_CNT_W       = $clog2(ACT_HOLD_CYCLES + 1);

   // Current owner of the external memory port
   typedef enum logic [1:0] {
      OWNER_NONE = 2'd0,
      OWNER_COPY = 2'd1,
      OWNER_TAPE = 2'd2
   } mem_owner_t;

endpackage

`default_nettype wire

// File: logic/ddr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ddr_arbiter
   import msx_media_pkg::*;
(
   input  logic      clock_bus,
   input  logic      rst_n,
   // Copier side
   input  logic      copy_rd,
   input  ddr_addr_t copy_addr,
   output logic      copy_ready,
   // Player side
   input  logic      tape_rd,
   input  ddr_addr_t tape_addr,
   output logic      tape_ready,
   // External memory
   output logic      mem_rd,
   output ddr_addr_t mem_addr,
   input  logic      mem_ready
);

   mem_owner_t owner;

   // Ready goes back only to the client holding the grant
   assign copy_ready = mem_ready & (owner == OWNER_COPY);
   assign tape_ready = mem_ready & (owner == OWNER_TAPE);

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         owner  <= OWNER_NONE;
         mem_rd <= 1'b0;
      end else if (owner == OWNER_NONE) begin
         // Copier wins over the tape player
         if (copy_rd) begin
            owner  <= OWNER_COPY;
            mem_rd <= 1'b1;
         end else if (tape_rd) begin
            owner  <= OWNER_TAPE;
            mem_rd <= 1'b1;
         end
      end else if (mem_ready) begin
         // One idle cycle after each completed read
         owner  <= OWNER_NONE;
         mem_rd <= 1'b0;
      end
   end

   // Address captured at grant time
   always_ff @(posedge clock_bus) begin
      if (owner == OWNER_NONE) begin
         mem_addr <= copy_rd ? copy_addr : tape_addr;
      end
   end

   a_ready_has_owner: assert property (@(posedge clock_bus) disable iff (!rst_n)
      mem_ready |-> (owner != OWNER_NONE));

   // Owner keeps its address until its read completes
   a_addr_of_owner: assert property (@(posedge clock_bus) disable iff (!rst_n)
      mem_rd |-> (mem_addr == ((owner == OWNER_COPY) ? copy_addr : tape_addr)));

endmodule

`default_nettype wire

// File: logic/pack_copier.sv
`timescale 1ns/1ps
`default_nettype none

module pack_copier
   import msx_media_pkg::*;
(
   input  logic      clock_bus,
   input  logic      rst_n,
   input  logic      copy_start,
   input  ddr_addr_t copy_src,
   input  ram_addr_t copy_dst,
   input  copy_len_t copy_len,
   input  logic      mem_ready,
   input  byte_t     mem_dout,
   output logic      mem_rd,
   output ddr_addr_t mem_addr,
   output ram_addr_t ram_addr,
   output byte_t     ram_din,
   output logic      ram_we,
   output logic      copy_busy
);

   typedef enum logic [1:0] {
      CP_IDLE = 2'd0,
      CP_READ = 2'd1,
      CP_DONE = 2'd2
   } cp_state_t;

   cp_state_t state;
   ddr_addr_t src_q;
   ram_addr_t dst_q;
   copy_len_t left_q;

   // Read stays requested across bytes so the grant returns here first
   assign mem_rd   = (state == CP_READ);
   assign mem_addr = src_q;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         state     <= CP_IDLE;
         copy_busy <= 1'b0;
         ram_we    <= 1'b0;
      end else begin
         ram_we <= 1'b0;
         case (state)
            CP_IDLE: begin
               if (copy_start) begin
                  copy_busy <= 1'b1;
                  state     <= (copy_len == '0) ? CP_DONE : CP_READ;
               end
            end
            CP_READ: begin
               if (mem_ready) begin
                  ram_we <= 1'b1;
                  if (left_q == copy_len_t'(1)) begin
                     state <= CP_DONE;
                  end
               end
            end
            CP_DONE: begin
               // Last write is on the RAM port this cycle
               copy_busy <= 1'b0;
               state     <= CP_IDLE;
            end
            default: state <= CP_IDLE;
         endcase
      end
   end

   // Block pointers and the RAM write data
   always_ff @(posedge clock_bus) begin
      if (state == CP_IDLE && copy_start) begin
         src_q  <= copy_src;
         dst_q  <= copy_dst;
         left_q <= copy_len;
      end else if (state == CP_READ && mem_ready) begin
         ram_addr <= dst_q;
         ram_din  <= mem_dout;
         src_q    <= src_q + 1'b1;
         dst_q    <= dst_q + 1'b1;
         left_q   <= left_q - 1'b1;
      end
   end

   a_we_in_busy: assert property (@(posedge clock_bus) disable iff (!rst_n)
      ram_we |-> copy_busy);

endmodule

`default_nettype wire

// File: logic/cas_player.sv
`timescale 1ns/1ps
`default_nettype none

module cas_player
   import msx_media_pkg::*;
(
   input  logic      clock_bus,
   input  logic      rst_n,
   input  logic      cas_download,
   input  logic      motor_n,
   input  logic      rewind,
   input  logic      mem_ready,
   input  byte_t     mem_dout,
   output logic      mem_rd,
   output ddr_addr_t mem_addr,
   output logic      cas_out
);

   logic              dl_q;
   logic              cas_load;
   logic              playing;
   logic              restart;
   logic              drop;
   logic              got_byte;
   logic              issue;
   ddr_addr_t         idx;
   byte_t             pf_buf;
   logic              pf_valid;
   byte_t             shift_q;
   logic [2:0]        bits_left;
   logic [TICK_W-1:0] tick;
   logic              sh_active;
   logic              shift_busy;
   logic              take_pf;
   logic              take_mem;
   logic              bit_q;

   assign playing    = cas_load & ~motor_n;
   assign restart    = rewind | cas_download;
   assign got_byte   = mem_ready & ~drop;
   assign issue      = ~mem_rd & playing & ~pf_valid & ~restart;
   assign shift_busy = sh_active & ((tick != '0) | (bits_left != '0));
   assign take_pf    = playing & ~shift_busy & pf_valid;
   assign take_mem   = playing & ~shift_busy & ~pf_valid & got_byte;
   assign cas_out    = playing & bit_q;

   always_ff @(posedge clock_bus) begin
      if (!rst_n) begin
         dl_q      <= 1'b0;
         cas_load  <= 1'b0;
         idx       <= '0;
         mem_rd    <= 1'b0;
         drop      <= 1'b0;
         pf_valid  <= 1'b0;
         sh_active <= 1'b0;
         bits_left <= '0;
         tick      <= '0;
         bit_q     <= 1'b0;
      end else begin
         // Tape counts as loaded once the download ends
         dl_q <= cas_download;
         if (dl_q && !cas_download) begin
            cas_load <= 1'b1;
         end
         if (mem_rd) begin
            if (mem_ready) begin
               mem_rd <= 1'b0;
               drop   <= 1'b0;
            end
         end else if (issue) begin
            mem_rd <= 1'b1;
         end
         if (restart) begin
            idx       <= '0;
            pf_valid  <= 1'b0;
            sh_active <= 1'b0;
            bit_q     <= 1'b0;
            // A read in flight belongs to the old position
            if (mem_rd && !mem_ready) begin
               drop <= 1'b1;
            end
         end else begin
            if (got_byte) begin
               idx <= idx + 1'b1;
            end
            if (playing && shift_busy) begin
               if (tick != '0) begin
                  tick <= tick - 1'b1;
               end else begin
                  bit_q     <= shift_q[7];
                  bits_left <= bits_left - 1'b1;
                  tick      <= TICK_W'(BIT_TICKS - 1);
               end
            end else if (take_pf || take_mem) begin
               bit_q     <= take_pf ? pf_buf[7] : mem_dout[7];
               bits_left <= 3'd7;
               tick      <= TICK_W'(BIT_TICKS - 1);
               sh_active <= 1'b1;
            end else if (playing) begin
               // Starved player keeps its last bit on the line
               sh_active <= 1'b0;
            end
            if (got_byte && !take_mem) begin
               pf_valid <= 1'b1;
            end else if (take_pf) begin
               pf_valid <= 1'b0;
            end
         end
      end
   end

   // Shift data, prefetch byte and read address
   always_ff @(posedge clock_bus) begin
      if (playing && shift_busy && tick == '0) begin
         shift_q <= {shift_q[6:0], 1'b0};
      end else if (take_pf) begin
         shift_q <= {pf_buf[6:0], 1'b0};
      end else if (take_mem) begin
         shift_q <= {mem_dout[6:0], 1'b0};
      end
      if (got_byte && !take_mem) begin
         pf_buf <= mem_dout;
      end
      if (issue) begin
         mem_addr <= TAPE_BASE + idx;
      end
   end

endmodule

`default_nettype wire

// File: logic/sd_activity.sv
`timescale 1ns/1ps
`default_nettype none

module sd_activity
   import msx_media_pkg::*;
(
   input  logic clock_bus,
   input  logic rst_n,
   input  logic sd_mosi,
   input  logic sd_miso,
   output logic sd_act
);

   logic                 mosi_q;
   logic                 miso_q;
   logic                 toggled;
   logic [ACT_CNT_W-1:0] hold_cnt;

   assign toggled = (sd_mosi ^ mosi_q) | (sd_miso ^ miso_q);
   assign sd_act  = (hold_cnt < ACT_CNT_W'(ACT_HOLD_CYCLES));

   always_ff @(posedge clock_bus) begin
      // Previous line levels follow the pins even in reset
      mosi_q <= sd_mosi;
      miso_q <= sd_miso;
      if (!rst_n) begin
         hold_cnt <= ACT_CNT_W'(ACT_HOLD_CYCLES);
      end else if (toggled) begin
         // Cycle of the change counts as the first
         hold_cnt <= ACT_CNT_W'(1);
      end else if (sd_act) begin
         hold_cnt <= hold_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: logic/msx_media_top.sv
`timescale 1ns/1ps
`default_nettype none

module msx_media_top
   import msx_media_pkg::*;
(
   input  logic      clock_bus,
   input  logic      rst_n,
   // Copy control
   input  logic      copy_start,
   input  ddr_addr_t copy_src,
   input  ram_addr_t copy_dst,
   input  copy_len_t copy_len,
   // Tape control
   input  logic      cas_download,
   input  logic      motor_n,
   input  logic      rewind,
   // External memory
   input  byte_t     mem_dout,
   input  logic      mem_ready,
   // SD lines
   input  logic      sd_mosi,
   input  logic      sd_miso,
   output logic      mem_rd,
   output ddr_addr_t mem_addr,
   // System RAM write port
   output ram_addr_t ram_addr,
   output byte_t     ram_din,
   output logic      ram_we,
   output logic      copy_busy,
   output logic      cas_out,
   output logic      sd_act
);

   logic      copy_rd;
   ddr_addr_t copy_addr;
   logic      copy_ready;
   logic      tape_rd;
   ddr_addr_t tape_addr;
   logic      tape_ready;

   // ====================
   // Memory sharing
   // ====================
   ddr_arbiter u_arbiter (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .copy_rd    (copy_rd),
      .copy_addr  (copy_addr),
      .copy_ready (copy_ready),
      .tape_rd    (tape_rd),
      .tape_addr  (tape_addr),
      .tape_ready (tape_ready),
      .mem_rd     (mem_rd),
      .mem_addr   (mem_addr),
      .mem_ready  (mem_ready)
   );

   // ====================
   // Clients
   // ====================
   pack_copier u_copier (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .copy_start (copy_start),
      .copy_src   (copy_src),
      .copy_dst   (copy_dst),
      .copy_len   (copy_len),
      .mem_ready  (copy_ready),
      .mem_dout   (mem_dout),
      .mem_rd     (copy_rd),
      .mem_addr   (copy_addr),
      .ram_addr   (ram_addr),
      .ram_din    (ram_din),
      .ram_we     (ram_we),
      .copy_busy  (copy_busy)
   );

   cas_player u_player (
      .clock_bus    (clock_bus),
      .rst_n        (rst_n),
      .cas_download (cas_download),
      .motor_n      (motor_n),
      .rewind       (rewind),
      .mem_ready    (tape_ready),
      .mem_dout     (mem_dout),
      .mem_rd       (tape_rd),
      .mem_addr     (tape_addr),
      .cas_out      (cas_out)
   );

   // Disk light
   sd_activity u_sd_act (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .sd_mosi   (sd_mosi),
      .sd_miso   (sd_miso),
      .sd_act    (sd_act)
   );

endmodule

`default_nettype wire

// File: dv/ext_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module ext_mem_model
   import msx_media_pkg::*;
(
   input  logic      clock_bus,
   input  logic      mem_rd,
   input  ddr_addr_t mem_addr,
   output logic      mem_ready,
   output byte_t     mem_dout
);

   integer    seed;
   logic      pending;
   logic      was_ready;
   int        wait_cnt;
   ddr_addr_t req_addr;

   initial begin
      seed      = 32'h225a_641a;
      mem_ready = 1'b0;
      mem_dout  = '0;
      pending   = 1'b0;
      wait_cnt  = 0;
      req_addr  = '0;
   end

   // Outputs change a little after the rising edge
   always begin
      @(posedge clock_bus);
      #1;
      was_ready = mem_ready;
      mem_ready = 1'b0;
      if (pending) begin
         if (wait_cnt == 0) begin
            // Data is the low address byte with a fixed XOR
            mem_ready = 1'b1;
            mem_dout  = req_addr[7:0] ^ 8'hA5;
            pending   = 1'b0;
         end else begin
            wait_cnt = wait_cnt - 1;
         end
      end else if (mem_rd && !was_ready) begin
         pending  = 1'b1;
         req_addr = mem_addr;
         // 1 to 4 cycles of latency
         wait_cnt = {$random(seed)} % 4;
      end
   end

endmodule

`default_nettype wire

// File: dv/tb_msx_media.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_media
   import msx_media_pkg::*;
();

   typedef enum {OP_IDLE, OP_COPY, OP_TAPE, OP_REWIND, OP_SD} op_t;

   localparam int        MAX_ROWS  = 8;
   localparam int        WD_MARGIN = 2000;
   localparam ddr_addr_t TAPE_SPAN = 28'h0001000;

   logic      clock_bus;
   logic      rst_n;
   logic      copy_start;
   ddr_addr_t copy_src;
   ram_addr_t copy_dst;
   copy_len_t copy_len;
   logic      cas_download;
   logic      motor_n;
   logic      rewind;
   byte_t     mem_dout;
   logic      mem_ready;
   logic      sd_mosi;
   logic      sd_miso;
   logic      mem_rd;
   ddr_addr_t mem_addr;
   ram_addr_t ram_addr;
   byte_t     ram_din;
   logic      ram_we;
   logic      copy_busy;
   logic      cas_out;
   logic      sd_act;

   // ====================
   // Stimulus table
   // ====================
   string       row_name [MAX_ROWS];
   op_t         row_op   [MAX_ROWS];
   ddr_addr_t   row_src  [MAX_ROWS];
   ram_addr_t   row_dst  [MAX_ROWS];
   int          row_len  [MAX_ROWS];
   logic [31:0] row_exp  [MAX_ROWS];
   int          n_rows;
   logic        table_ready;

   string     cur_name;
   int        row_errors;
   int        monitor_errors;
   int        cyc;
   int        last_we_cyc;
   int        tape_done_cnt;
   logic      tape_on;
   ddr_addr_t tape_next;
   ddr_addr_t last_tape_addr;
   ram_addr_t wr_addr_q [$];
   byte_t     wr_data_q [$];

   msx_media_top u_dut (
      .clock_bus    (clock_bus),
      .rst_n        (rst_n),
      .copy_start   (copy_start),
      .copy_src     (copy_src),
      .copy_dst     (copy_dst),
      .copy_len     (copy_len),
      .cas_download (cas_download),
      .motor_n      (motor_n),
      .rewind       (rewind),
      .mem_dout     (mem_dout),
      .mem_ready    (mem_ready),
      .sd_mosi      (sd_mosi),
      .sd_miso      (sd_miso),
      .mem_rd       (mem_rd),
      .mem_addr     (mem_addr),
      .ram_addr     (ram_addr),
      .ram_din      (ram_din),
      .ram_we       (ram_we),
      .copy_busy    (copy_busy),
      .cas_out      (cas_out),
      .sd_act       (sd_act)
   );

   ext_mem_model u_mem (
      .clock_bus (clock_bus),
      .mem_rd    (mem_rd),
      .mem_addr  (mem_addr),
      .mem_ready (mem_ready),
      .mem_dout  (mem_dout)
   );

   always #50 clock_bus = ~clock_bus;

   always @(posedge clock_bus) begin
      cyc <= cyc + 1;
   end

   function automatic byte_t model_byte(input ddr_addr_t a);
      return a[7:0] ^ 8'hA5;
   endfunction

   function automatic logic is_tape_addr(input ddr_addr_t a);
      return (a >= TAPE_BASE) && (a < TAPE_BASE + TAPE_SPAN);
   endfunction

   task automatic add_row(input string name, input op_t op, input ddr_addr_t src,
                          input ram_addr_t dst, input int len, input logic [31:0] exp_val);
      row_name[n_rows] = name;
      row_op[n_rows]   = op;
      row_src[n_rows]  = src;
      row_dst[n_rows]  = dst;
      row_len[n_rows]  = len;
      row_exp[n_rows]  = exp_val;
      n_rows++;
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      row_errors++;
      $display("CHECK FAILED %s %s expected %0h actual %0h", cur_name, what, exp_val, act_val);
   endtask

   // Inputs change 1 ns after the rising edge
   task automatic next_drive_slot();
      @(posedge clock_bus);
      #1;
   endtask

   // Monitor of RAM writes and tape read order at the falling edge
   always @(negedge clock_bus) begin
      if (ram_we) begin
         wr_addr_q.push_back(ram_addr);
         wr_data_q.push_back(ram_din);
         last_we_cyc = cyc;
      end
      if (mem_ready && is_tape_addr(mem_addr)) begin
         if (mem_addr != TAPE_BASE + tape_next) begin
            monitor_errors++;
            $display("CHECK FAILED %s tape_index expected %0h actual %0h",
                     cur_name, TAPE_BASE + tape_next, mem_addr);
         end
         tape_next      = mem_addr - TAPE_BASE + 1'b1;
         last_tape_addr = mem_addr;
         tape_done_cnt++;
      end
   end

   task automatic hold_idle(input int len, input logic [31:0] exp_val);
      repeat (len + 1) @(negedge clock_bus);
      if ({mem_rd, ram_we, copy_busy, cas_out, sd_act} != exp_val[4:0])
         report_mismatch("idle_outputs", exp_val, {mem_rd, ram_we, copy_busy, cas_out, sd_act});
   endtask

   task automatic copy_block(input ddr_addr_t src, input ram_addr_t dst, input int len,
                             input logic [31:0] exp_val);
      int k;
      int n;
      wr_addr_q.delete();
      wr_data_q.delete();
      next_drive_slot();
      copy_start = 1'b1;
      copy_src   = src;
      copy_dst   = dst;
      copy_len   = copy_len_t'(len);
      next_drive_slot();
      copy_start = 1'b0;
      @(negedge clock_bus);
      if (!copy_busy) report_mismatch("copy_busy_rise", 1, copy_busy);
      while (copy_busy) @(negedge clock_bus);
      if (len > 0 && cyc != last_we_cyc + 1)
         report_mismatch("busy_fall_cycle", last_we_cyc + 1, cyc);
      if (wr_addr_q.size() != exp_val) report_mismatch("write_count", exp_val, wr_addr_q.size());
      for (k = 0; k < wr_addr_q.size(); k++) begin
         if (wr_addr_q[k] != ram_addr_t'(dst + k))
            report_mismatch("ram_addr", ram_addr_t'(dst + k), wr_addr_q[k]);
         if (wr_data_q[k] != model_byte(ddr_addr_t'(src + k)))
            report_mismatch("ram_din", model_byte(ddr_addr_t'(src + k)), wr_data_q[k]);
      end
      // Tape must get the port back once the copy is over
      if (tape_on) begin
         n = tape_done_cnt;
         wait (tape_done_cnt > n);
      end
   endtask

   task automatic play_tape(input logic [31:0] exp_val);
      int n;
      int j;
      byte_t b;
      next_drive_slot();
      cas_download = 1'b1;
      tape_next    = '0;
      next_drive_slot();
      cas_download = 1'b0;
      motor_n      = 1'b0;
      tape_on      = 1'b1;
      @(negedge clock_bus);
      while (!(mem_ready && is_tape_addr(mem_addr))) @(negedge clock_bus);
      // Sample mid window with bits in MSB first order
      for (n = 0; n < exp_val; n++) begin
         b = model_byte(TAPE_BASE + n);
         for (j = 7; j >= 0; j--) begin
            repeat ((n == 0 && j == 7) ? BIT_TICKS / 2 : BIT_TICKS) @(negedge clock_bus);
            if (cas_out !== b[j]) report_mismatch("cas_out", b[j], cas_out);
         end
      end
   endtask

   task automatic rewind_tape(input int len, input logic [31:0] exp_val);
      int quiet;
      int base;
      next_drive_slot();
      motor_n = 1'b1;
      // Let any read in flight finish first
      quiet = 0;
      while (quiet < 4) begin
         @(negedge clock_bus);
         quiet = mem_rd ? 0 : quiet + 1;
      end
      next_drive_slot();
      rewind    = 1'b1;
      tape_next = '0;
      base      = tape_done_cnt;
      next_drive_slot();
      rewind  = 1'b0;
      motor_n = 1'b0;
      wait (tape_done_cnt > base);
      if (last_tape_addr != exp_val) report_mismatch("first_read_addr", exp_val, last_tape_addr);
      wait (tape_done_cnt >= base + len);
   endtask

   task automatic toggle_sd_lines(input int gap, input logic [31:0] exp_val);
      int k;
      next_drive_slot();
      sd_mosi = ~sd_mosi;
      if (gap > 0) begin
         repeat (gap) next_drive_slot();
         sd_miso = ~sd_miso;
      end
      @(negedge clock_bus);
      if (gap == 0 && sd_act) report_mismatch("sd_act_early", 0, sd_act);
      @(negedge clock_bus);
      if (!sd_act) report_mismatch("sd_act_rise", 1, sd_act);
      k = 1;
      while (sd_act) begin
         @(negedge clock_bus);
         k++;
      end
      if (k != exp_val) report_mismatch("sd_hold_cycles", exp_val, k);
   endtask

   // ====================
   // Main sequence
   // ====================
   initial begin
      int r;
      n_rows = 0;
      add_row("reset_state",   OP_IDLE,   '0,           '0,           0,  0);
      add_row("copy_block",    OP_COPY,   28'h00012F8, 27'h0004000, 12, 12);
      add_row("copy_empty",    OP_COPY,   28'h0000100, 27'h0000200, 0,  0);
      add_row("tape_stream",   OP_TAPE,   '0,           '0,           3,  3);
      add_row("copy_priority", OP_COPY,   28'h00A00F6, 27'h0001234, 16, 16);
      add_row("tape_rewind",   OP_REWIND, '0,           '0,           3,  TAPE_BASE);
      add_row("sd_single",     OP_SD,     '0,           '0,           0,  ACT_HOLD_CYCLES);
      add_row("sd_retrigger",  OP_SD,     '0,           '0,           20, ACT_HOLD_CYCLES);
      table_ready = 1'b1;

      clock_bus      = 1'b0;
      rst_n          = 1'b0;
      copy_start     = 1'b0;
      copy_src       = '0;
      copy_dst       = '0;
      copy_len       = '0;
      cas_download   = 1'b0;
      motor_n        = 1'b1;
      rewind         = 1'b0;
      sd_mosi        = 1'b0;
      sd_miso        = 1'b0;
      cur_name       = "reset";
      row_errors     = 0;
      monitor_errors = 0;
      cyc            = 0;
      last_we_cyc    = 0;
      tape_done_cnt  = 0;
      tape_on        = 1'b0;
      tape_next      = '0;
      last_tape_addr = '0;

      repeat (2) @(posedge clock_bus);
      #1;
      rst_n = 1'b1;

      for (r = 0; r < n_rows; r++) begin
         cur_name = row_name[r];
         case (row_op[r])
            OP_IDLE:   hold_idle(row_len[r], row_exp[r]);
            OP_COPY:   copy_block(row_src[r], row_dst[r], row_len[r], row_exp[r]);
            OP_TAPE:   play_tape(row_exp[r]);
            OP_REWIND: rewind_tape(row_len[r], row_exp[r]);
            OP_SD:     toggle_sd_lines(row_len[r], row_exp[r]);
            default:   report_mismatch("row_op", 0, row_op[r]);
         endcase
      end

      repeat (4) @(posedge clock_bus);
      $display("run done: row errors %0d, monitor errors %0d", row_errors, monitor_errors);
      if (row_errors + monitor_errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // Watchdog sized from the table
   initial begin
      int budget;
      int r;
      wait (table_ready);
      budget = WD_MARGIN;
      for (r = 0; r < n_rows; r++) begin
         budget += row_len[r] * 10;
      end
      repeat (budget) @(posedge clock_bus);
      $display("timeout: run did not finish within %0d cycles in %s", budget, cur_name);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
logic/msx_media_pkg.sv
logic/ddr_arbiter.sv
logic/pack_copier.sv
logic/cas_player.sv
logic/sd_activity.sv
logic/msx_media_top.sv
dv/ext_mem_model.sv
dv/tb_msx_media.sv
